//--- Makefile
VERILATOR ?= verilator
TOP       ?= pix_controller_tb
RTL_TOP   ?= pix_controller
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
source/pix_pkg.sv
source/pix_cmd_port.sv
source/pix_frame_capture.sv
source/pix_fifo.sv
source/block_ram_ctrl.sv
source/pix_transfer_seq.sv
source/pix_controller.sv
sim/pix_controller_tb.sv

//--- sim/pix_controller_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pix_controller_tb import pix_pkg::*; ();

    localparam int IMAGE_SIZE       = 16;
    localparam int FIFO_DEPTH       = 8;
    localparam int RAM_WRITE_CYCLES = 2;
    localparam int IDX_W            = $clog2(IMAGE_SIZE);

    // Frame shape
    localparam int GARBAGE_CYCLES = 12;
    localparam int LINE_LEN       = 4;
    localparam int LINE_GAP       = 3;
    localparam int OVERRUN_PIXELS = 24;
    localparam int LONG_HOLD      = 6;
    localparam int IDLE_CYCLES    = 10;

    // Worst-case test lengths in clock cycles
    localparam int HANDSHAKE_CYCLES = 20;
    localparam int RESET_CYCLES     = 6;
    localparam int CAPTURE_CYCLES   = GARBAGE_CYCLES + 5 +
        (IMAGE_SIZE / LINE_LEN) * (LINE_LEN + LINE_GAP) +
        RAM_WRITE_CYCLES * IMAGE_SIZE + HANDSHAKE_CYCLES;
    localparam int READOUT_CYCLES   = 8 * IMAGE_SIZE + HANDSHAKE_CYCLES + LONG_HOLD;
    localparam int OVERRUN_CYCLES   = GARBAGE_CYCLES + 5 + OVERRUN_PIXELS + HANDSHAKE_CYCLES;
    localparam int RUN_CYCLES       = 2 * RESET_CYCLES + 2 * CAPTURE_CYCLES +
        4 * READOUT_CYCLES + OVERRUN_CYCLES + IDLE_CYCLES;
    localparam int TIMEOUT_CYCLES   = 4 * RUN_CYCLES;

    logic   clk;
    logic   rst_n;
    logic   cmd_req;
    cmd_e   cmd_op;
    block_t cmd_block;
    logic   cmd_ack;
    pixel_t pix_d;
    logic   pix_fv;
    logic   pix_lv;
    logic   readout_ready;
    logic   readout_trigger = 1'b0;
    word_t  readout_data;
    logic   capture_overrun;

    // Reference copy of the frame memory with one row per block
    word_t       model_mem [8][IMAGE_SIZE];
    block_t      read_block;
    int          read_count = 0;
    word_t       expected_word;
    logic        consume_en;
    logic        overrun_expected;
    logic [31:0] pixel_seed = 32'd53771;
    logic [31:0] stall_seed = 32'd53771;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count;

    pix_controller #(
        .IMAGE_SIZE(IMAGE_SIZE),
        .FIFO_DEPTH(FIFO_DEPTH),
        .RAM_WRITE_CYCLES(RAM_WRITE_CYCLES)
    ) dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .cmd_req(cmd_req),
        .cmd_op(cmd_op),
        .cmd_block(cmd_block),
        .cmd_ack(cmd_ack),
        .pix_d(pix_d),
        .pix_fv(pix_fv),
        .pix_lv(pix_lv),
        .readout_ready(readout_ready),
        .readout_trigger(readout_trigger),
        .readout_data(readout_data),
        .capture_overrun(capture_overrun)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_error(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        error_count++;
    endtask

    // ======================================================================
    // Readout consumer
    // ======================================================================

    assign expected_word = model_mem[read_block][IDX_W'(read_count)];

    always @(posedge clk) begin
        if (!consume_en) begin
            readout_trigger <= 1'b0;
            read_count      <= 0;
        end else begin
            if (readout_trigger && readout_ready) begin
                read_count <= read_count + 1;
            end
            // Roughly one word in four, so the readout FIFO backs up
            stall_seed = xorshift32(stall_seed);
            readout_trigger <= (stall_seed[1:0] == 2'b00);
        end
    end

    // ======================================================================
    // Checkers
    // ======================================================================

    reset_values_check: assert property (@(posedge clk)
        $rose(rst_n) |-> (!cmd_ack && !readout_ready && !capture_overrun &&
                          dut_i.ram_cmd_ready && !dut_i.ram_cmd_trigger &&
                          !dut_i.ram_write_trigger && !dut_i.ram_read_trigger))
        else report_error("outputs or memory triggers not at reset values after reset");

    readout_data_check: assert property (@(posedge clk) disable iff (!rst_n)
        (readout_ready && readout_trigger) |-> (readout_data == expected_word))
        else report_error("readout word differs from the captured pixel");

    readout_count_check: assert property (@(posedge clk) disable iff (!rst_n)
        (readout_ready && readout_trigger) |-> (read_count < IMAGE_SIZE))
        else report_error("readout delivered more words than one block holds");

    readout_ack_check: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(cmd_ack) && consume_en) |-> (read_count == IMAGE_SIZE && !readout_ready))
        else report_error("readout ack rose before the last word was consumed");

    ack_needs_req_check: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> cmd_req)
        else report_error("cmd_ack rose while cmd_req was low");

    ack_hold_check: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_ack && cmd_req) |=> cmd_ack)
        else report_error("cmd_ack fell while cmd_req was still high");

    ack_release_check: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_ack && !cmd_req) |=> !cmd_ack)
        else report_error("cmd_ack did not fall the cycle after cmd_req fell");

    overrun_check: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(capture_overrun) |-> overrun_expected)
        else report_error("capture_overrun rose during a frame the FIFO can absorb");

    // ======================================================================
    // Stimulus tasks
    // ======================================================================

    task automatic apply_reset();
        rst_n            <= 1'b0;
        cmd_req          <= 1'b0;
        pix_fv           <= 1'b0;
        pix_lv           <= 1'b0;
        consume_en       <= 1'b0;
        overrun_expected <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    task automatic issue_command(input cmd_e op, input block_t blk);
        @(posedge clk);
        cmd_op    <= op;
        cmd_block <= blk;
        cmd_req   <= 1'b1;
    endtask

    task automatic wait_for_ack();
        while (!cmd_ack) begin
            @(posedge clk);
        end
    endtask

    task automatic release_command(input int hold);
        repeat (hold) @(posedge clk);
        @(posedge clk);
        cmd_req <= 1'b0;
        while (cmd_ack) begin
            @(posedge clk);
        end
    endtask

    // Tail of a frame already in progress, a blank gap, then the real frame
    task automatic drive_frame(input block_t blk, input int n_pixels,
                               input int line_len, input int gap);
        int     sent;
        int     col;
        pixel_t px;
        sent = 0;
        repeat (GARBAGE_CYCLES) begin
            @(posedge clk);
            pixel_seed = xorshift32(pixel_seed);
            pix_fv <= 1'b1;
            pix_lv <= pixel_seed[12];
            pix_d  <= pixel_seed[11:0];
        end
        repeat (3) begin
            @(posedge clk);
            pix_fv <= 1'b0;
            pix_lv <= 1'b0;
        end
        @(posedge clk);
        pix_fv <= 1'b1;
        while (sent < n_pixels) begin
            col = 0;
            while (col < line_len && sent < n_pixels) begin
                @(posedge clk);
                pixel_seed = xorshift32(pixel_seed);
                px = pixel_seed[11:0];
                pix_lv <= 1'b1;
                pix_d  <= px;
                if (sent < IMAGE_SIZE) begin
                    model_mem[blk][IDX_W'(sent)] = {4'h0, px};
                end
                sent++;
                col++;
            end
            repeat (gap) begin
                @(posedge clk);
                pix_lv <= 1'b0;
            end
        end
        @(posedge clk);
        pix_fv <= 1'b0;
        pix_lv <= 1'b0;
    endtask

    task automatic run_readout(input block_t blk, input int hold);
        read_block = blk;
        issue_command(CMD_READOUT, blk);
        consume_en <= 1'b1;
        wait_for_ack();
        assert (read_count == IMAGE_SIZE)
            else report_error($sformatf("block %0d gave %0d words", blk, read_count));
        consume_en <= 1'b0;
        release_command(hold);
    endtask

    task automatic close_test(input string name, input int mark);
        tests_run++;
        if (error_count == mark) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, error_count - mark);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        int mark;
        rst_n            = 1'b0;
        cmd_req          = 1'b0;
        cmd_op           = CMD_CAPTURE;
        cmd_block        = '0;
        pix_d            = '0;
        pix_fv           = 1'b0;
        pix_lv           = 1'b0;
        consume_en       = 1'b0;
        overrun_expected = 1'b0;
        read_block       = '0;
        apply_reset();

        mark = error_count;
        repeat (2) @(posedge clk);
        close_test("1 reset values", mark);

        mark = error_count;
        issue_command(CMD_CAPTURE, 3'd2);
        drive_frame(3'd2, IMAGE_SIZE, LINE_LEN, LINE_GAP);
        wait_for_ack();
        release_command(0);
        close_test("2 capture into block 2", mark);

        mark = error_count;
        run_readout(3'd2, 0);
        close_test("3 readout of block 2", mark);

        // Second block with fresh data, then both read back
        mark = error_count;
        issue_command(CMD_CAPTURE, 3'd5);
        drive_frame(3'd5, IMAGE_SIZE, LINE_LEN, LINE_GAP);
        wait_for_ack();
        release_command(0);
        run_readout(3'd2, 0);
        run_readout(3'd5, 0);
        close_test("4 independent blocks 2 and 5", mark);

        mark = error_count;
        repeat (IDLE_CYCLES) @(posedge clk);
        run_readout(3'd5, LONG_HOLD);
        close_test("5 handshake order", mark);

        // FIFO drains at half the pixel rate, so a long line overflows it
        mark = error_count;
        overrun_expected <= 1'b1;
        issue_command(CMD_CAPTURE, 3'd7);
        drive_frame(3'd7, OVERRUN_PIXELS, OVERRUN_PIXELS, 0);
        assert (capture_overrun)
            else report_error("capture_overrun low after a line longer than the FIFO");
        apply_reset();
        @(posedge clk);
        close_test("6 capture overrun", mark);

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/block_ram_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module block_ram_ctrl import pix_pkg::*; #(
    parameter int IMAGE_SIZE       = 64,
    parameter int RAM_WRITE_CYCLES = 2
) (
    input  logic   clk,
    input  logic   rst_n,
    output logic   cmd_ready,
    input  logic   cmd_trigger,
    input  logic   cmd_write,
    input  block_t cmd_block,
    output logic   write_ready,
    input  logic   write_trigger,
    input  word_t  write_data,
    output logic   read_ready,
    input  logic   read_trigger,
    output word_t  read_data
);

    localparam int ADDR_W = $clog2(8 * IMAGE_SIZE);
    localparam int CNT_W  = $clog2(IMAGE_SIZE);
    localparam int WAIT_W = $clog2(RAM_WRITE_CYCLES + 1);

    word_t             mem [8 * IMAGE_SIZE];
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] fetch_addr;
    logic [CNT_W-1:0]  word_cnt;
    logic [WAIT_W-1:0] wait_cnt;
    logic              write_mode;
    logic              accept;
    logic              write_xfer;
    logic              read_xfer;
    logic              last_word;
    logic              fetch;

    // ======================================================================
    // Handshake decode
    // ======================================================================

    assign accept      = cmd_trigger && cmd_ready;
    assign write_ready = !cmd_ready && write_mode && (wait_cnt == '0);
    assign write_xfer  = write_ready && write_trigger;
    assign read_xfer   = read_ready && read_trigger;
    assign last_word   = (word_cnt == CNT_W'(IMAGE_SIZE - 1));
    assign start_addr  = ADDR_W'(cmd_block) * ADDR_W'(IMAGE_SIZE);

    // Read data is prefetched so the next word waits at read_data
    assign fetch      = (accept && !cmd_write) || (read_xfer && !last_word);
    assign fetch_addr = accept ? start_addr : addr + 1'b1;

    // ======================================================================
    // Block sequencing
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_ready  <= 1'b1;
            read_ready <= 1'b0;
            write_mode <= 1'b0;
            addr       <= '0;
            word_cnt   <= '0;
            wait_cnt   <= '0;
        end else if (accept) begin
            cmd_ready  <= 1'b0;
            read_ready <= !cmd_write;
            write_mode <= cmd_write;
            addr       <= start_addr;
            word_cnt   <= '0;
            wait_cnt   <= '0;
        end else begin
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
            if (write_xfer || read_xfer) begin
                addr     <= addr + 1'b1;
                word_cnt <= word_cnt + 1'b1;
                if (write_xfer) begin
                    wait_cnt <= WAIT_W'(RAM_WRITE_CYCLES - 1);
                end
                // Whole block moved, ready for the next command
                if (last_word) begin
                    cmd_ready  <= 1'b1;
                    read_ready <= 1'b0;
                    write_mode <= 1'b0;
                end
            end
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (write_xfer) begin
            mem[addr] <= write_data;
        end
        if (fetch) begin
            read_data <= mem[fetch_addr];
        end
    end

endmodule

`default_nettype wire

//--- source/pix_cmd_port.sv
`timescale 1ns/100ps
`default_nettype none

module pix_cmd_port import pix_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cmd_req,
    input  cmd_e   cmd_op,
    input  block_t cmd_block,
    output logic   cmd_ack,
    output logic   start_capture,
    output logic   start_readout,
    output block_t op_block,
    input  logic   op_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_ACKED
    } state_e;

    state_e state;

    // Four-phase handshake, start pulse follows the rising req by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            cmd_ack       <= 1'b0;
            start_capture <= 1'b0;
            start_readout <= 1'b0;
            op_block      <= '0;
        end else begin
            start_capture <= 1'b0;
            start_readout <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_req && !cmd_ack) begin
                        op_block      <= cmd_block;
                        start_capture <= (cmd_op == CMD_CAPTURE);
                        start_readout <= (cmd_op == CMD_READOUT);
                        state         <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (op_done) begin
                        cmd_ack <= 1'b1;
                        state   <= ST_ACKED;
                    end
                end
                ST_ACKED: begin
                    // Hold ack until the master drops req
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/pix_controller.sv
`timescale 1ns/100ps
`default_nettype none

module pix_controller import pix_pkg::*; #(
    parameter int IMAGE_SIZE       = 64,
    parameter int FIFO_DEPTH       = 8,
    parameter int RAM_WRITE_CYCLES = 2
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cmd_req,
    input  cmd_e   cmd_op,
    input  block_t cmd_block,
    output logic   cmd_ack,
    input  pixel_t pix_d,
    input  logic   pix_fv,
    input  logic   pix_lv,
    output logic   readout_ready,
    input  logic   readout_trigger,
    output word_t  readout_data,
    output logic   capture_overrun
);

    // ======================================================================
    // Internal nets
    // ======================================================================

    logic   start_capture;
    logic   start_readout;
    block_t op_block;
    logic   op_done;
    logic   arm;

    logic   cap_push;
    pixel_t cap_push_data;
    logic   cap_full;
    logic   cap_pop;
    pixel_t cap_data;
    logic   cap_empty;

    logic   rd_push;
    word_t  rd_push_data;
    logic   rd_full;
    logic   rd_empty;

    logic   ram_cmd_ready;
    logic   ram_cmd_trigger;
    logic   ram_cmd_write;
    block_t ram_cmd_block;
    logic   ram_write_ready;
    logic   ram_write_trigger;
    word_t  ram_write_data;
    logic   ram_read_ready;
    logic   ram_read_trigger;
    word_t  ram_read_data;

    assign readout_ready = !rd_empty;

    // ======================================================================
    // Decode, execute and result stages
    // ======================================================================

    pix_cmd_port cmd_port_i (
        .clk(clk), .rst_n(rst_n),
        .cmd_req(cmd_req), .cmd_op(cmd_op), .cmd_block(cmd_block), .cmd_ack(cmd_ack),
        .start_capture(start_capture), .start_readout(start_readout),
        .op_block(op_block), .op_done(op_done)
    );

    // Overrun flag restarts with each capture command
    pix_frame_capture capture_i (
        .clk(clk), .rst_n(rst_n), .arm(arm),
        .pix_d(pix_d), .pix_fv(pix_fv), .pix_lv(pix_lv),
        .fifo_push(cap_push), .fifo_data(cap_push_data), .fifo_full(cap_full),
        .capture_overrun(capture_overrun), .clear_overrun(start_capture)
    );

    pix_fifo #(.payload_t(pixel_t), .FIFO_DEPTH(FIFO_DEPTH)) cap_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(cap_push), .push_data(cap_push_data), .full(cap_full),
        .pop(cap_pop), .pop_data(cap_data), .empty(cap_empty)
    );

    pix_transfer_seq seq_i (
        .clk(clk), .rst_n(rst_n),
        .start_capture(start_capture), .start_readout(start_readout),
        .op_block(op_block), .op_done(op_done), .arm(arm),
        .cmd_ready(ram_cmd_ready), .cmd_trigger(ram_cmd_trigger),
        .cmd_write(ram_cmd_write), .cmd_block(ram_cmd_block),
        .write_ready(ram_write_ready), .write_trigger(ram_write_trigger),
        .write_data(ram_write_data),
        .read_ready(ram_read_ready), .read_trigger(ram_read_trigger),
        .read_data(ram_read_data),
        .cap_pop(cap_pop), .cap_data(cap_data), .cap_empty(cap_empty),
        .rd_push(rd_push), .rd_data(rd_push_data), .rd_full(rd_full), .rd_empty(rd_empty)
    );

    block_ram_ctrl #(
        .IMAGE_SIZE(IMAGE_SIZE),
        .RAM_WRITE_CYCLES(RAM_WRITE_CYCLES)
    ) ram_i (
        .clk(clk), .rst_n(rst_n),
        .cmd_ready(ram_cmd_ready), .cmd_trigger(ram_cmd_trigger),
        .cmd_write(ram_cmd_write), .cmd_block(ram_cmd_block),
        .write_ready(ram_write_ready), .write_trigger(ram_write_trigger),
        .write_data(ram_write_data),
        .read_ready(ram_read_ready), .read_trigger(ram_read_trigger),
        .read_data(ram_read_data)
    );

    pix_fifo #(.payload_t(word_t), .FIFO_DEPTH(FIFO_DEPTH)) rd_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(rd_push), .push_data(rd_push_data), .full(rd_full),
        .pop(readout_trigger), .pop_data(readout_data), .empty(rd_empty)
    );

endmodule

`default_nettype wire

//--- source/pix_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module pix_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  FIFO_DEPTH = 8
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t   mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic       do_push;
    logic       do_pop;

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/pix_frame_capture.sv
`timescale 1ns/100ps
`default_nettype none

module pix_frame_capture import pix_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   arm,
    input  pixel_t pix_d,
    input  logic   pix_fv,
    input  logic   pix_lv,
    output logic   fifo_push,
    output pixel_t fifo_data,
    input  logic   fifo_full,
    output logic   capture_overrun,
    input  logic   clear_overrun
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_INVALID,
        ST_WAIT_START,
        ST_ACTIVE
    } state_e;

    state_e state;
    logic   pix_valid_q;
    pixel_t pix_q;

    // A whole frame is taken, so sync to a frame boundary first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:         if (arm) state <= ST_WAIT_INVALID;
                ST_WAIT_INVALID: if (!pix_fv) state <= ST_WAIT_START;
                ST_WAIT_START:   if (pix_fv) state <= ST_ACTIVE;
                ST_ACTIVE:       if (!pix_fv) state <= ST_IDLE;
                default:         state <= ST_IDLE;
            endcase
        end
    end

    // Sample register, the first line may start with the frame edge itself
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_valid_q <= 1'b0;
        end else begin
            pix_valid_q <= pix_fv && pix_lv &&
                           (state == ST_ACTIVE || state == ST_WAIT_START);
        end
    end

    always_ff @(posedge clk) begin
        pix_q <= pix_d;
    end

    assign fifo_push = pix_valid_q && !fifo_full;
    assign fifo_data = pix_q;

    // Camera cannot be stalled, a full FIFO loses the pixel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            capture_overrun <= 1'b0;
        end else if (clear_overrun) begin
            capture_overrun <= 1'b0;
        end else if (pix_valid_q && fifo_full) begin
            capture_overrun <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/pix_pkg.sv
`default_nettype none

package pix_pkg;

    // ======================================================================
    // Data types shared by the capture path, the memory and the readout
    // ======================================================================

    // One sensor sample
    typedef logic [11:0] pixel_t;

    // One frame memory word, pixels are zero-extended into it
    typedef logic [15:0] word_t;

    // Frame memory block number, eight blocks
    typedef logic [2:0] block_t;

    // Command carried on the req/ack port
    typedef enum logic {
        CMD_CAPTURE = 1'b0,
        CMD_READOUT = 1'b1
    } cmd_e;

endpackage

`default_nettype wire

//--- source/pix_transfer_seq.sv
`timescale 1ns/100ps
`default_nettype none

module pix_transfer_seq import pix_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start_capture,
    input  logic   start_readout,
    input  block_t op_block,
    output logic   op_done,
    output logic   arm,
    input  logic   cmd_ready,
    output logic   cmd_trigger,
    output logic   cmd_write,
    output block_t cmd_block,
    input  logic   write_ready,
    output logic   write_trigger,
    output word_t  write_data,
    input  logic   read_ready,
    output logic   read_trigger,
    input  word_t  read_data,
    output logic   cap_pop,
    input  pixel_t cap_data,
    input  logic   cap_empty,
    output logic   rd_push,
    output word_t  rd_data,
    input  logic   rd_full,
    input  logic   rd_empty
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CAP_CMD,
        ST_CAP_COPY,
        ST_RD_CMD,
        ST_RD_DRAIN
    } state_e;

    state_e state;

    // Refill the pending write word once memory takes the previous one
    assign cap_pop = (state == ST_CAP_COPY) && !cap_empty &&
                     (!write_trigger || write_ready);

    // Memory pauses whenever the readout FIFO has no room
    assign read_trigger = (state == ST_RD_DRAIN) && !rd_full;
    assign rd_push      = read_trigger && read_ready;
    assign rd_data      = read_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            op_done       <= 1'b0;
            arm           <= 1'b0;
            cmd_trigger   <= 1'b0;
            cmd_write     <= 1'b0;
            cmd_block     <= '0;
            write_trigger <= 1'b0;
        end else begin
            op_done <= 1'b0;
            arm     <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_capture || start_readout) begin
                        cmd_block   <= op_block;
                        cmd_write   <= start_capture;
                        cmd_trigger <= 1'b1;
                        state       <= start_capture ? ST_CAP_CMD : ST_RD_CMD;
                    end
                end
                // Hold the write command until memory accepts it
                ST_CAP_CMD: begin
                    if (cmd_ready && cmd_trigger) begin
                        cmd_trigger <= 1'b0;
                        arm         <= 1'b1;
                        state       <= ST_CAP_COPY;
                    end
                end
                ST_CAP_COPY: begin
                    if (cap_pop) begin
                        write_trigger <= 1'b1;
                    end else if (write_ready && write_trigger) begin
                        write_trigger <= 1'b0;
                    end
                    // Memory back to ready means the block is full
                    if (cmd_ready) begin
                        write_trigger <= 1'b0;
                        op_done       <= 1'b1;
                        state         <= ST_IDLE;
                    end
                end
                ST_RD_CMD: begin
                    if (cmd_ready && cmd_trigger) begin
                        cmd_trigger <= 1'b0;
                        state       <= ST_RD_DRAIN;
                    end
                end
                ST_RD_DRAIN: begin
                    // Done once memory is finished and the consumer took everything
                    if (cmd_ready && rd_empty) begin
                        op_done <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cap_pop) begin
            write_data <= word_t'(cap_data);
        end
    end

endmodule

`default_nettype wire
